// ==== rtl/des_defines.svh ====
`ifndef DES_DEFINES_SVH
`define DES_DEFINES_SVH

// feistel rounds per block
`define DES_ROUNDS 16

// one round key after PC-2
`define DES_SUBKEY_W 48

// job slots between the pipeline and the checker
`define DES_FIFO_DEPTH 4

`endif

// ==== rtl/des_pkg.sv ====
`include "des_defines.svh"

package des_pkg;

    typedef logic [63:0] block_t;
    typedef logic [`DES_SUBKEY_W-1:0] subkey_t;
    // 768 bits with index 0 as the first round
    typedef subkey_t [`DES_ROUNDS-1:0] round_keys_t;

    typedef struct packed {
        block_t      message;
        round_keys_t round_keys;
        block_t      result;
    } des_job_t;

    // tables number bits from 1 at the msb
    localparam int unsigned IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int unsigned FP_TAB [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam int unsigned E_TAB [48] = '{
        32, 1, 2, 3, 4, 5,
        4, 5, 6, 7, 8, 9,
        8, 9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32, 1
    };

    localparam int unsigned P_TAB [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17,
        1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9,
        19, 13, 30, 6, 22, 11, 4, 25
    };

    // entry index is row * 16 + column
    localparam logic [3:0] SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    function automatic block_t init_perm(block_t blk);
        block_t perm;
        for (int i = 0; i < 64; i++) begin
            perm[63-i] = blk[64-IP_TAB[i]];
        end
        return perm;
    endfunction

    // takes the state after round 16, undoes the last swap, then IP^-1
    function automatic block_t final_perm(block_t state);
        block_t preout;
        block_t perm;
        preout = {state[31:0], state[63:32]};
        for (int i = 0; i < 64; i++) begin
            perm[63-i] = preout[64-FP_TAB[i]];
        end
        return perm;
    endfunction

    // one feistel round on {l, r}
    function automatic block_t des_round(block_t state, subkey_t key);
        logic [31:0] l;
        logic [31:0] r;
        logic [47:0] x;
        logic [31:0] s_out;
        logic [31:0] f_out;
        logic [5:0]  six;
        l = state[63:32];
        r = state[31:0];
        for (int i = 0; i < 48; i++) begin
            x[47-i] = r[32-E_TAB[i]];
        end
        x = x ^ key;
        for (int s = 0; s < 8; s++) begin
            six = x[47-6*s -: 6];
            // outer bits pick the row
            s_out[31-4*s -: 4] = SBOX[s][{six[5], six[0], six[4:1]}];
        end
        for (int i = 0; i < 32; i++) begin
            f_out[31-i] = s_out[32-P_TAB[i]];
        end
        return {r, l ^ f_out};
    endfunction

endpackage

// ==== rtl/des_job_if.sv ====
`timescale 1ns/1ps

interface des_job_if;

    logic                    push;
    des_pkg::block_t         message;
    des_pkg::round_keys_t    round_keys;
    des_pkg::block_t         result;

    modport producer (
        output push, message, round_keys, result
    );

    // fields qualified by push in the same cycle
    modport buffer (
        input push, message, round_keys, result
    );

endinterface

// ==== rtl/des_pipelined.sv ====
`timescale 1ns/1ps
`include "des_defines.svh"

module des_pipelined (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  admit,
    input  des_pkg::block_t       message,
    input  des_pkg::round_keys_t  round_keys,
    des_job_if.producer           job
);

    localparam int LAST = `DES_ROUNDS - 1;

    logic [`DES_ROUNDS-1:0] valid_q;
    des_pkg::block_t        state_q [`DES_ROUNDS];
    des_pkg::block_t        msg_q   [`DES_ROUNDS];
    des_pkg::round_keys_t   keys_q  [`DES_ROUNDS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LAST-1:0], admit};
        end
    end

    // stage k holds the state after round k+1
    always_ff @(posedge clk) begin
        state_q[0] <= des_pkg::des_round(des_pkg::init_perm(message), round_keys[0]);
        msg_q[0]   <= message;
        keys_q[0]  <= round_keys;
        for (int k = 1; k < `DES_ROUNDS; k++) begin
            state_q[k] <= des_pkg::des_round(state_q[k-1], keys_q[k-1][k]);
            msg_q[k]   <= msg_q[k-1];
            keys_q[k]  <= keys_q[k-1];
        end
    end

    // job leaves with its inputs so the checker can redo it
    assign job.push       = valid_q[LAST];
    assign job.message    = msg_q[LAST];
    assign job.round_keys = keys_q[LAST];
    assign job.result     = des_pkg::final_perm(state_q[LAST]);

endmodule

// ==== rtl/job_fifo.sv ====
`timescale 1ns/1ps
`include "des_defines.svh"

module job_fifo #(
    parameter type payload_t = des_pkg::des_job_t,
    parameter int  DEPTH     = `DES_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       admit,
    des_job_if.buffer  job,
    input  logic       pop,
    output logic       empty,
    output payload_t   head_job,
    output logic       busy
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    payload_t   wr_data;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;
    logic             pop_ok;

    assign wr_data = payload_t'({job.message, job.round_keys, job.result});
    assign pop_ok  = pop && !empty;

    always_ff @(posedge clk) begin
        if (job.push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            // credits reserve a slot for every push
            if (job.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({job.push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // stored plus in flight
            case ({admit, pop_ok})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign empty    = (count == '0);
    assign head_job = mem[rd_ptr];
    assign busy     = (credits == CNT_W'(DEPTH));

endmodule

// ==== rtl/des_crosscheck.sv ====
`timescale 1ns/1ps
`include "des_defines.svh"

module des_crosscheck (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                empty,
    input  des_pkg::des_job_t   head_job,
    output logic                pop,
    output logic                done,
    output des_pkg::block_t     result,
    output logic                mismatch
);

    localparam int CNT_W = $clog2(`DES_ROUNDS + 1);

    typedef enum logic {
        IDLE,
        RUN
    } fsm_t;

    fsm_t                 fsm_q;
    logic [CNT_W-1:0]     round_q;
    des_pkg::block_t      state_q;
    des_pkg::round_keys_t keys_q;
    des_pkg::block_t      expect_q;
    des_pkg::block_t      cipher;
    logic                 done_q;
    logic                 mismatch_q;
    des_pkg::block_t      result_q;

    assign pop    = (fsm_q == IDLE) && !empty;
    assign cipher = des_pkg::final_perm(state_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm_q      <= IDLE;
            round_q    <= '0;
            done_q     <= 1'b0;
            mismatch_q <= 1'b0;
        end else begin
            done_q     <= 1'b0;
            mismatch_q <= 1'b0;
            case (fsm_q)
                IDLE: begin
                    if (pop) begin
                        fsm_q   <= RUN;
                        round_q <= '0;
                    end
                end
                RUN: begin
                    if (round_q == CNT_W'(`DES_ROUNDS)) begin
                        // all rounds applied so report and go back
                        fsm_q      <= IDLE;
                        done_q     <= 1'b1;
                        mismatch_q <= (cipher != expect_q);
                    end else begin
                        round_q <= round_q + 1'b1;
                    end
                end
                default: fsm_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            state_q  <= des_pkg::init_perm(head_job.message);
            keys_q   <= head_job.round_keys;
            expect_q <= head_job.result;
        end else if (fsm_q == RUN && round_q != CNT_W'(`DES_ROUNDS)) begin
            state_q <= des_pkg::des_round(state_q, keys_q[round_q]);
        end
        if (fsm_q == RUN && round_q == CNT_W'(`DES_ROUNDS)) begin
            result_q <= cipher;
        end
    end

    assign done     = done_q;
    assign mismatch = mismatch_q;
    assign result   = result_q;

endmodule

// ==== rtl/des_eval_top.sv ====
`timescale 1ns/1ps

module des_eval_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  des_pkg::block_t       message,
    input  des_pkg::round_keys_t  round_keys,
    output logic                  busy,
    output logic                  done,
    output des_pkg::block_t       result,
    output logic                  mismatch
);

    logic               admit;
    logic               pop;
    logic               empty;
    des_pkg::des_job_t  head_job;

    des_job_if job_bus ();

    // starts while busy are dropped
    assign admit = start && !busy;

    des_pipelined i_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .admit      (admit),
        .message    (message),
        .round_keys (round_keys),
        .job        (job_bus.producer)
    );

    job_fifo #(
        .payload_t (des_pkg::des_job_t)
    ) i_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .admit    (admit),
        .job      (job_bus.buffer),
        .pop      (pop),
        .empty    (empty),
        .head_job (head_job),
        .busy     (busy)
    );

    des_crosscheck i_check (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .head_job (head_job),
        .pop      (pop),
        .done     (done),
        .result   (result),
        .mismatch (mismatch)
    );

endmodule

// ==== verification/tb_des_eval.sv ====
`timescale 1ns/1ps
`include "des_defines.svh"

module tb_des_eval;

    localparam int MAX_VEC   = 16;
    localparam int WAIT_MAX  = 200;
    localparam int DRAIN_MAX = 2000;
    localparam int QUIET     = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    des_pkg::block_t      message;
    des_pkg::round_keys_t round_keys;
    logic                 busy;
    logic                 done;
    des_pkg::block_t      result;
    logic                 mismatch;

    des_pkg::round_keys_t keysets [4];
    int                   vec_ks  [MAX_VEC];
    des_pkg::block_t      vec_msg [MAX_VEC];
    des_pkg::block_t      vec_exp [MAX_VEC];
    // expected ciphertexts of admitted starts in order
    des_pkg::block_t      exp_q [$];
    string                test_name;
    int                   test_errs;
    int                   n_pass;
    int                   n_fail;

    des_eval_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .message    (message),
        .round_keys (round_keys),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .mismatch   (mismatch)
    );

    always #2 clk = ~clk;

    task automatic check_block(string what, des_pkg::block_t want, des_pkg::block_t got);
        if (got !== want) begin
            $display("Fail %s: expected %h, got %h", what, want, got);
            test_errs++;
        end
    endtask

    task automatic check_flag(string what, logic want, logic got);
        if (got !== want) begin
            $display("Fail %s: expected %b, got %b", what, want, got);
            test_errs++;
        end
    endtask

    task automatic close_run();
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        $display("timeout while waiting for %s in test %s", what, test_name);
        n_fail++;
        close_run();
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            n_fail++;
        end
    endtask

    // advance one cycle and read outputs on the falling edge
    task automatic tick();
        des_pkg::block_t want;
        @(negedge clk);
        if (done) begin
            if (exp_q.size() == 0) begin
                $display("%s: done pulse without an admitted start", test_name);
                test_errs++;
            end else begin
                want = exp_q.pop_front();
                check_block({test_name, " result"}, want, result);
            end
            check_flag({test_name, " mismatch"}, 1'b0, mismatch);
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy) begin
            tick();
            n++;
            if (n > WAIT_MAX) begin
                give_up("busy to fall");
            end
        end
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            tick();
            n++;
            if (n > DRAIN_MAX) begin
                give_up("outstanding results");
            end
        end
        // a stray done shows up within this window
        repeat (QUIET) tick();
    endtask

    task automatic drive_vector(int v);
        message    = vec_msg[v];
        round_keys = keysets[vec_ks[v]];
    endtask

    // spaced starts given only while busy is low
    task automatic run_spaced(int starts, int nvec);
        int gap;
        for (int i = 0; i < starts; i++) begin
            gap = $urandom_range(3, 0);
            repeat (gap) tick();
            wait_not_busy();
            drive_vector(i % nvec);
            start = 1'b1;
            exp_q.push_back(vec_exp[i % nvec]);
            tick();
            start = 1'b0;
        end
        drain_results();
    endtask

    // start held every cycle while busy picks the ones that get in
    task automatic run_burst(int starts, int nvec);
        int   since_empty;
        logic seen_busy;
        since_empty = 0;
        seen_busy   = 1'b0;
        for (int i = 0; i < starts; i++) begin
            drive_vector(i % nvec);
            start = 1'b1;
            if (exp_q.size() == 0) begin
                since_empty = 0;
                seen_busy   = 1'b0;
            end
            if (busy) begin
                seen_busy = 1'b1;
            end else begin
                exp_q.push_back(vec_exp[i % nvec]);
                since_empty++;
                if (since_empty > `DES_FIFO_DEPTH && !seen_busy) begin
                    $display("%s: busy still low after %0d admitted starts",
                             test_name, since_empty);
                    test_errs++;
                end
            end
            tick();
        end
        start = 1'b0;
        check_flag({test_name, " busy seen"}, starts > `DES_FIFO_DEPTH, seen_busy);
        drain_results();
    endtask

    initial begin
        int               fd;
        int               id;
        int               starts;
        int               nvec;
        string            tok;
        string            mode;
        string            rest;
        des_pkg::subkey_t k;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        message    = '0;
        round_keys = '0;
        n_pass     = 0;
        n_fail     = 0;
        test_errs  = 0;
        test_name  = "reset_state";
        void'($urandom(32'h8c27));

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset_state busy", 1'b0, busy);
        check_flag("reset_state done", 1'b0, done);
        check_flag("reset_state mismatch", 1'b0, mismatch);
        // any done in this idle window is flagged by tick
        repeat (QUIET) tick();
        report_test();

        fd = $fopen("verification/des_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/des_tests.txt");
            n_fail++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (tok == "keyset") begin
                    void'($fscanf(fd, "%d", id));
                    for (int r = 0; r < `DES_ROUNDS; r++) begin
                        void'($fscanf(fd, "%h", k));
                        keysets[id][r] = k;
                    end
                end else if (tok == "test") begin
                    void'($fscanf(fd, "%s %s %d %d", test_name, mode, starts, nvec));
                    for (int v = 0; v < nvec; v++) begin
                        void'($fscanf(fd, "%d %h %h", vec_ks[v], vec_msg[v], vec_exp[v]));
                    end
                    test_errs = 0;
                    if (mode == "burst") begin
                        run_burst(starts, nvec);
                    end else begin
                        run_spaced(starts, nvec);
                    end
                    report_test();
                end else begin
                    $display("unrecognised entry %s in the test file", tok);
                    n_fail++;
                end
            end
            $fclose(fd);
        end
        close_run();
    end

endmodule

// ==== verification/des_tests.txt ====
# keyset <id>, then 16 round keys in hex, round 1 first
# test <name> <single|burst> <starts> <vectors>, then per vector: <keyset> <message> <ciphertext>
keyset 0
1B02EFFC7072 79AED9DBC9E5 55FC8A42CF99 72ADD6DB351D
7CEC07EB53A8 63A53E507B2F EC84B7F618BC F78A3AC13BFB
E0DBEBEDE781 B1F347BA464F 215FD3DED386 7571F59467E9
97C5D1FABA41 5F43B7F2E73A BF918D3D3F0A CB3D8B0E17F5
# same schedule reversed, which decrypts
keyset 1
CB3D8B0E17F5 BF918D3D3F0A 5F43B7F2E73A 97C5D1FABA41
7571F59467E9 215FD3DED386 B1F347BA464F E0DBEBEDE781
F78A3AC13BFB EC84B7F618BC 63A53E507B2F 7CEC07EB53A8
72ADD6DB351D 55FC8A42CF99 79AED9DBC9E5 1B02EFFC7072
# weak key 0101010101010101, all round keys zero
keyset 2
000000000000 000000000000 000000000000 000000000000
000000000000 000000000000 000000000000 000000000000
000000000000 000000000000 000000000000 000000000000
000000000000 000000000000 000000000000 000000000000
test single_tutorial single 1 1
0 0123456789ABCDEF 85E813540F0AB405
test single_inverse single 1 1
1 85E813540F0AB405 0123456789ABCDEF
test single_weak single 1 1
2 8000000000000000 95F8A5E5DD31D900
test result_order single 5 5
2 4000000000000000 DD7F121CA5015619
0 0123456789ABCDEF 85E813540F0AB405
2 2000000000000000 2E8653104F3834EA
1 85E813540F0AB405 0123456789ABCDEF
2 95F8A5E5DD31D900 8000000000000000
test burst_mixed burst 24 6
2 1000000000000000 4BD388FF6CD81D4F
2 0800000000000000 20B9E767B2FB1456
0 0123456789ABCDEF 85E813540F0AB405
2 0400000000000000 55579380D77138EF
1 85E813540F0AB405 0123456789ABCDEF
2 0200000000000000 6CC5DEFAAF04512F
test burst_long burst 48 4
2 0100000000000000 0D9F279BA5D87260
2 0080000000000000 D9031B0271BD5A0A
2 0040000000000000 424250B37C3DD951
2 DD7F121CA5015619 4000000000000000

// ==== flist.f ====
+incdir+rtl
rtl/des_pkg.sv
rtl/des_job_if.sv
rtl/des_pipelined.sv
rtl/job_fifo.sv
rtl/des_crosscheck.sv
rtl/des_eval_top.sv
verification/tb_des_eval.sv

// ==== Bender.yml ====
package:
  name: des_eval

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/des_pkg.sv
      - rtl/des_job_if.sv
      - rtl/des_pipelined.sv
      - rtl/job_fifo.sv
      - rtl/des_crosscheck.sv
      - rtl/des_eval_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/tb_des_eval.sv
